// File: list.f
+incdir+src
src/eth_fcs_pkg.sv
src/eth_crc_8.sv
src/axis_skid_buf.sv
src/eth_fcs_check.sv
src/fcs_stat_apb.sv
src/eth_fcs_rx_top.sv
sim/eth_fcs_checker.sv
sim/eth_fcs_tb.sv

// File: Makefile
# Verilator build and run of the receive FCS testbench

SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = eth_fcs_tb
FILELIST = list.f
LOG      = sim.log
FAIL_MSG = tests failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: sim/eth_fcs_tb.sv
// ######################################################################
// Directed testbench for the receive FCS path. Sends frames with a
// reference CRC-32, records the output stream and reads the counters.
// ######################################################################

`default_nettype none

`include "eth_fcs_cfg.svh"

module eth_fcs_tb
    import eth_fcs_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] REF_POLY = 32'hEDB8_8320;
    localparam int          LIMIT    = 2000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic [7:0]             s_data;
    logic                   s_valid;
    logic                   s_ready;
    logic                   s_last;
    logic                   s_user;
    logic [7:0]             m_data;
    logic                   m_valid;
    logic                   m_ready = 1'b1;
    logic                   m_last;
    logic                   m_user;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic [31:0]            lfsr  = 32'h610f;
    logic                   bp_en = 1'b0;
    logic [9:0]             rx_q[$];
    logic [9:0]             exp_q[$];
    int                     errors = 0;
    int                     tests  = 0;

    always #20 clk = ~clk;

    eth_fcs_rx_top dut0 (.*);

    // beat {data, last, user} is taken on the next rising edge
    always @(negedge clk) begin
        if (!rst && m_valid && m_ready) begin
            rx_q.push_back({m_data, m_last, m_user});
        end
    end

    always @(posedge clk) begin
        #2;
        if (bp_en) begin
            m_ready <= rand_bit();
        end else begin
            m_ready <= 1'b1;
        end
    end

    // galois form stepped once per bit
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // payload of 1 to 36 bytes for frames of 5 to 40
    function automatic int rand_len();
        return 1 + int'(rand_bits(6) % 36);
    endfunction

    // bit serial with the lsb of each byte first
    function automatic logic [31:0] crc_ref(input logic [7:0] bytes[$]);
        logic [31:0] crc;
        logic        fb;
        crc = 32'hFFFF_FFFF;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = crc[0] ^ bytes[i][b];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ REF_POLY;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("tests failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int e0);
        tests++;
        $display("%s: finished with %0d errors", name, errors - e0);
    endtask

    // called and returning 2 ns after a rising edge
    task automatic apb_access(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int n;
        n = 0;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            n++;
            if (n > LIMIT) begin
                stop_on_timeout("pready");
            end
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic read_reg(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        compare_value(32'(err), 32'd0, "pslverr on a mapped read");
    endtask

    task automatic read_counts(output logic [31:0] good, output logic [31:0] bad);
        read_reg(REG_GOOD, good);
        read_reg(REG_BAD, bad);
    endtask

    task automatic make_payload(input int len, output logic [7:0] pay[$]);
        pay = {};
        for (int i = 0; i < len; i++) begin
            pay.push_back(8'(rand_bits(8)));
        end
    endtask

    // flip < 0 keeps the fcs intact
    task automatic send_frame(input logic [7:0] pay[$], input int flip, input logic user_last);
        logic [7:0]  frame[$];
        logic [31:0] fcs;
        logic        last_b;
        int          n;
        frame = pay;
        fcs = crc_ref(pay);
        if (flip >= 0) begin
            fcs[flip] = ~fcs[flip];
        end
        for (int i = 0; i < 4; i++) begin
            frame.push_back(fcs[8*i +: 8]);
        end
        foreach (pay[i]) begin
            last_b = (i == pay.size() - 1);
            exp_q.push_back({pay[i], last_b, last_b & (user_last | (flip >= 0))});
        end
        foreach (frame[i]) begin
            s_data = frame[i];
            s_last = (i == frame.size() - 1);
            s_user = user_last & s_last;
            s_valid = 1'b1;
            n = 0;
            @(negedge clk);
            while (!s_ready) begin
                n++;
                if (n > LIMIT) begin
                    stop_on_timeout("s_ready");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #2;
        end
        s_valid = 1'b0;
        s_last = 1'b0;
        s_user = 1'b0;
    endtask

    task automatic check_output(input string name);
        logic [9:0] got;
        logic [9:0] exp;
        int         n;
        n = 0;
        while (rx_q.size() < exp_q.size()) begin
            n++;
            if (n > LIMIT) begin
                stop_on_timeout("output beats");
            end
            @(posedge clk);
            #2;
        end
        // a few idle cycles to catch extra beats
        repeat (3) @(posedge clk);
        #2;
        compare_value(32'(rx_q.size()), 32'(exp_q.size()), {name, " beat count"});
        while (rx_q.size() > 0 && exp_q.size() > 0) begin
            got = rx_q.pop_front();
            exp = exp_q.pop_front();
            compare_value(32'(got), 32'(exp), {name, " beat {data,last,user}"});
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic test_reset();
        logic [31:0] d;
        int          e0;
        e0 = errors;
        repeat (3) begin
            @(negedge clk);
            compare_value(32'(s_ready), 32'd0, "s_ready in reset");
            compare_value(32'(m_valid), 32'd0, "m_valid in reset");
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        compare_value(32'(s_ready), 32'd0, "s_ready after reset");
        compare_value(32'(m_valid), 32'd0, "m_valid after reset");
        @(posedge clk);
        #2;
        read_reg(REG_GOOD, d);
        compare_value(d, 32'd0, "good count after reset");
        read_reg(REG_BAD, d);
        compare_value(d, 32'd0, "bad count after reset");
        report_test("reset_state", e0);
    endtask

    task automatic test_good();
        logic [7:0]  pay[$];
        logic [31:0] g0;
        logic [31:0] b0;
        logic [31:0] g1;
        logic [31:0] b1;
        int          e0;
        e0 = errors;
        read_counts(g0, b0);
        // shortest and longest frames first, then random lengths
        make_payload(1, pay);
        send_frame(pay, -1, 1'b0);
        make_payload(36, pay);
        send_frame(pay, -1, 1'b0);
        for (int f = 0; f < 4; f++) begin
            make_payload(rand_len(), pay);
            send_frame(pay, -1, 1'b0);
        end
        check_output("good_frames");
        read_counts(g1, b1);
        compare_value(g1 - g0, 32'd6, "good count increase");
        compare_value(b1 - b0, 32'd0, "bad count increase");
        report_test("good_frames", e0);
    endtask

    // kind 0 good fcs, 1 flipped fcs bit, 2 upstream user flag
    task automatic frame_with_flags(input string name, input int kind);
        logic [7:0]  pay[$];
        logic [31:0] g0;
        logic [31:0] b0;
        logic [31:0] g1;
        logic [31:0] b1;
        int          e0;
        e0 = errors;
        read_counts(g0, b0);
        make_payload(rand_len(), pay);
        send_frame(pay, (kind == 1) ? int'(rand_bits(5)) : -1, kind == 2);
        check_output(name);
        read_counts(g1, b1);
        compare_value(g1 - g0, (kind == 1) ? 32'd0 : 32'd1, "good count increase");
        compare_value(b1 - b0, (kind == 1) ? 32'd1 : 32'd0, "bad count increase");
        report_test(name, e0);
    endtask

    task automatic test_back_pressure();
        logic [7:0]  all[$];
        logic [7:0]  pay[$];
        int          lens[6];
        int          kinds[6];
        int          flips[6];
        logic [31:0] g0;
        logic [31:0] b0;
        logic [31:0] g1;
        logic [31:0] b1;
        int          pos;
        int          good_n;
        int          e0;
        e0 = errors;
        good_n = 0;
        read_counts(g0, b0);
        // all random draws happen before m_ready starts using the lfsr
        for (int f = 0; f < 6; f++) begin
            lens[f] = rand_len();
            // kind 2 flips an fcs bit and kind 3 sets the upstream user flag
            kinds[f] = f % 4;
            flips[f] = int'(rand_bits(5));
            make_payload(lens[f], pay);
            foreach (pay[i]) begin
                all.push_back(pay[i]);
            end
            if (kinds[f] != 2) begin
                good_n++;
            end
        end
        @(negedge clk);
        bp_en = 1'b1;
        @(posedge clk);
        #2;
        pos = 0;
        for (int f = 0; f < 6; f++) begin
            pay = {};
            for (int i = 0; i < lens[f]; i++) begin
                pay.push_back(all[pos + i]);
            end
            pos += lens[f];
            send_frame(pay, (kinds[f] == 2) ? flips[f] : -1, kinds[f] == 3);
        end
        check_output("back_pressure");
        @(negedge clk);
        bp_en = 1'b0;
        @(posedge clk);
        #2;
        read_counts(g1, b1);
        compare_value(g1 - g0, 32'(good_n), "good count increase");
        compare_value(b1 - b0, 32'(6 - good_n), "bad count increase");
        report_test("back_pressure", e0);
    endtask

    task automatic test_apb();
        logic [7:0]  pay[$];
        logic [31:0] d;
        logic        err;
        int          e0;
        e0 = errors;
        make_payload(20, pay);
        fork
            send_frame(pay, -1, 1'b0);
            begin
                repeat (8) @(posedge clk);
                #2;
                read_reg(REG_STATUS, d);
                compare_value(d, 32'd1, "busy in the status register");
            end
        join
        check_output("apb_frame");
        read_reg(REG_STATUS, d);
        compare_value(d, 32'd0, "status register between frames");
        apb_access(1'b1, REG_CTRL, 32'd1, d, err);
        compare_value(32'(err), 32'd0, "pslverr on the clear write");
        read_reg(REG_GOOD, d);
        compare_value(d, 32'd0, "good count after clear");
        read_reg(REG_BAD, d);
        compare_value(d, 32'd0, "bad count after clear");
        apb_access(1'b0, 4'h2, 32'd0, d, err);
        compare_value(32'(err), 32'd1, "pslverr on an unmapped address");
        report_test("apb_regs", e0);
    endtask

    initial begin
        rst = 1'b1;
        s_data = 8'd0;
        s_valid = 1'b0;
        s_last = 1'b0;
        s_user = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = 32'd0;
        test_reset();
        test_good();
        frame_with_flags("bad_fcs", 1);
        frame_with_flags("user_flag", 2);
        test_back_pressure();
        test_apb();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/eth_fcs_checker.sv
// ######################################################################
// Stream and APB protocol assertions, bound into the receive FCS top
// level by the bind statement at the end of this file.
// ######################################################################

`default_nettype none

module eth_fcs_checker (
    input logic       clk,
    input logic       rst,
    input logic [7:0] m_data,
    input logic       m_valid,
    input logic       m_ready,
    input logic       m_last,
    input logic       m_user,
    input logic       s_ready,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       frame_done,
    input logic       bad_fcs
);

    timeunit 1ns;
    timeprecision 100ps;

    // a stalled output beat stays frozen
    hold_beat: assert property (@(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> ($stable(m_data) && $stable(m_last) && $stable(m_user)))
        else $error("output beat changed while stalled");

    apb_ready: assert property (@(posedge clk) (psel && penable) |-> pready)
        else $error("pready low in the access phase");

    known_handshake: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({m_valid, s_ready}))
        else $error("unknown value on m_valid or s_ready");

    // a bad fcs is only ever flagged with its frame
    bad_with_done: assert property (@(posedge clk) disable iff (rst) bad_fcs |-> frame_done)
        else $error("bad_fcs without frame_done");

endmodule

bind eth_fcs_rx_top eth_fcs_checker chk_bind0 (
    .clk        (clk),
    .rst        (rst),
    .m_data     (m_data),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_last     (m_last),
    .m_user     (m_user),
    .s_ready    (s_ready),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .frame_done (frame_done),
    .bad_fcs    (bad_fcs)
);

`default_nettype wire

// File: src/eth_fcs_rx_top.sv
// ######################################################################
// Receive FCS subsystem top level. Joins the FCS checker to the APB
// statistics block, with the stream and APB ports brought out.
// ######################################################################

`default_nettype none

`include "eth_fcs_cfg.svh"

module eth_fcs_rx_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             s_data,
    input  logic                   s_valid,
    output logic                   s_ready,
    input  logic                   s_last,
    input  logic                   s_user,
    output logic [7:0]             m_data,
    output logic                   m_valid,
    input  logic                   m_ready,
    output logic                   m_last,
    output logic                   m_user,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr
);

    // status from the checker to the counters
    logic busy;
    logic frame_done;
    logic bad_fcs;

    eth_fcs_check chk0 (
        .clk        (clk),
        .rst        (rst),
        .s_data     (s_data),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .s_last     (s_last),
        .s_user     (s_user),
        .m_data     (m_data),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_last     (m_last),
        .m_user     (m_user),
        .busy       (busy),
        .frame_done (frame_done),
        .bad_fcs    (bad_fcs)
    );

    fcs_stat_apb stat0 (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .frame_done (frame_done),
        .bad_fcs    (bad_fcs),
        .busy       (busy)
    );

endmodule

`default_nettype wire

// File: src/fcs_stat_apb.sv
// ######################################################################
// APB register block with good and bad frame counters, a busy status
// bit and a counter clear. Answers every access without wait states.
// ######################################################################

`default_nettype none

`include "eth_fcs_cfg.svh"

module fcs_stat_apb
    import eth_fcs_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   frame_done,
    input  logic                   bad_fcs,
    input  logic                   busy
);

    logic [`FCS_CNT_W-1:0] good_cnt;
    logic [`FCS_CNT_W-1:0] bad_cnt;
    logic                  access;
    logic                  mapped;
    logic                  clr;

    assign access = psel & penable;
    assign pready = 1'b1;

    // read mux and address check
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            REG_GOOD:   prdata = 32'(good_cnt);
            REG_BAD:    prdata = 32'(bad_cnt);
            REG_CTRL:   prdata = '0;
            REG_STATUS: prdata = {31'd0, busy};
            default:    mapped = 1'b0;
        endcase
    end

    assign pslverr = access & ~mapped;
    assign clr     = access & pwrite & (paddr == REG_CTRL) & pwdata[0];

    // clear wins over a pulse on the same edge
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            good_cnt <= '0;
            bad_cnt  <= '0;
        end else if (frame_done) begin
            if (bad_fcs) begin
                bad_cnt <= bad_cnt + 1'b1;
            end else begin
                good_cnt <= good_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/eth_fcs_check.sv
// ######################################################################
// Ethernet FCS checker. Delays the stream by four bytes, runs CRC-32
// over the payload, strips the FCS and flags bad frames on the last beat.
// ######################################################################

`default_nettype none

`include "eth_fcs_cfg.svh"

module eth_fcs_check
    import eth_fcs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] s_data,
    input  logic       s_valid,
    output logic       s_ready,
    input  logic       s_last,
    input  logic       s_user,
    output logic [7:0] m_data,
    output logic       m_valid,
    input  logic       m_ready,
    output logic       m_last,
    output logic       m_user,
    output logic       busy,
    output logic       frame_done,
    output logic       bad_fcs
);

    typedef enum logic {
        ST_IDLE,
        ST_PAYLOAD
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic [3:0][7:0] dly_data;
    logic [3:0]      dly_vld;
    logic [31:0]     crc_q;
    logic [31:0]     crc_nx;
    logic            accept;
    logic            crc_bad;
    eth_beat_t       out_beat;
    logic            out_valid;

    assign accept = s_valid & s_ready;

    // the byte leaving the delay line is always payload
    eth_crc_8 crc0 (
        .data    (dly_data[3]),
        .crc_in  (crc_q),
        .crc_out (crc_nx)
    );

    // fcs is sent low byte first, so the byte on the bus is the top one
    assign crc_bad = {s_data, dly_data[0], dly_data[1], dly_data[2]} != ~crc_nx;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept & ~s_last) begin
                    state_d = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (accept & s_last) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // beat handed to the buffer, flags only matter on the last one
    always_comb begin
        out_beat.data = dly_data[3];
        out_beat.last = s_last;
        out_beat.user = s_last & (s_user | crc_bad);
    end

    assign out_valid = dly_vld[3] & s_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            dly_vld    <= '0;
            crc_q      <= `ETH_CRC_INIT;
            frame_done <= 1'b0;
            bad_fcs    <= 1'b0;
        end else begin
            state_q    <= state_d;
            frame_done <= accept & s_last;
            bad_fcs    <= accept & s_last & crc_bad;
            if (accept & s_last) begin
                // clear the line and start over for the next frame
                dly_vld <= '0;
                crc_q   <= `ETH_CRC_INIT;
            end else if (accept) begin
                dly_vld <= {dly_vld[2:0], 1'b1};
                if (dly_vld[3]) begin
                    crc_q <= crc_nx;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dly_data <= {dly_data[2:0], s_data};
        end
    end

    assign busy = (state_q == ST_PAYLOAD);

    axis_skid_buf obuf0 (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (out_beat),
        .in_valid    (out_valid),
        .ready_early (),
        .in_ready    (s_ready),
        .m_data      (m_data),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_last      (m_last),
        .m_user      (m_user)
    );

endmodule

`default_nettype wire

// File: src/axis_skid_buf.sv
// ######################################################################
// Output buffer with an output and a spare register. Lets the upstream
// ready be a flop without dropping a beat under back-pressure.
// ######################################################################

`default_nettype none

module axis_skid_buf
    import eth_fcs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  eth_beat_t  in_beat,
    input  logic       in_valid,
    output logic       ready_early,
    output logic       in_ready,
    output logic [7:0] m_data,
    output logic       m_valid,
    input  logic       m_ready,
    output logic       m_last,
    output logic       m_user
);

    eth_beat_t out_q;
    eth_beat_t spare_q;
    logic      out_vld;
    logic      spare_vld;
    logic      load_out_in;
    logic      load_out_spare;
    logic      load_spare_in;

    // room next cycle unless the spare fills or is already full
    assign ready_early = m_ready | (~spare_vld & (~out_vld | ~in_valid));

    assign load_out_in    = in_ready & (m_ready | ~out_vld);
    assign load_spare_in  = in_ready & ~m_ready & out_vld;
    assign load_out_spare = ~in_ready & m_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready  <= 1'b0;
            out_vld   <= 1'b0;
            spare_vld <= 1'b0;
        end else begin
            in_ready <= ready_early;
            if (load_out_in) begin
                out_vld <= in_valid;
            end else if (load_spare_in) begin
                spare_vld <= in_valid;
            end else if (load_out_spare) begin
                out_vld   <= spare_vld;
                spare_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_in) begin
            out_q <= in_beat;
        end else if (load_out_spare) begin
            out_q <= spare_q;
        end
        if (load_spare_in) begin
            spare_q <= in_beat;
        end
    end

    assign m_data  = out_q.data;
    assign m_last  = out_q.last;
    assign m_user  = out_q.user;
    assign m_valid = out_vld;

endmodule

`default_nettype wire

// File: src/eth_crc_8.sv
// ######################################################################
// One byte step of the reflected CRC-32 used by the Ethernet FCS.
// Purely combinational, feed the running CRC back through a register.
// ######################################################################

`default_nettype none

`include "eth_fcs_cfg.svh"

module eth_crc_8 (
    input  logic [7:0]  data,
    input  logic [31:0] crc_in,
    output logic [31:0] crc_out
);

    logic [31:0] crc;

    // lsb first, so the byte folds into the low end of the register
    always_comb begin
        crc = crc_in ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ `ETH_CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_out = crc;
    end

endmodule

`default_nettype wire

// File: src/eth_fcs_pkg.sv
// ######################################################################
// Types shared by the FCS checker, its output buffer and the APB
// register block. Modules pull them in by a wildcard import.
// ######################################################################

`default_nettype none

`include "eth_fcs_cfg.svh"

package eth_fcs_pkg;

    // one byte of the stream with its side flags
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } eth_beat_t;

    // register word addresses
    typedef enum logic [`APB_ADDR_W-1:0] {
        REG_GOOD   = 4'h0,
        REG_BAD    = 4'h4,
        REG_CTRL   = 4'h8,
        REG_STATUS = 4'hC
    } fcs_reg_e;

endpackage

`default_nettype wire

// File: src/eth_fcs_cfg.svh
// ######################################################################
// Shared constants for the Ethernet receive FCS path.
// Include in any file that needs the CRC values or the register widths.
// ######################################################################

`ifndef ETH_FCS_CFG_SVH
`define ETH_FCS_CFG_SVH

// reflected CRC-32 as used for the Ethernet FCS
`define ETH_CRC_INIT 32'hFFFF_FFFF
`define ETH_CRC_POLY 32'hEDB8_8320

// statistics counters and APB address bus
`define FCS_CNT_W 32
`define APB_ADDR_W 4

`endif
